//--- tomasulo_pkg.sv
package tomasulo_pkg;

// Data word on operands, results and the CDB
typedef logic [31:0] word_t;

// RV32I compare flavours, each gives 1 or 0
typedef enum logic [2:0] {
    CMP_EQ  = 3'd0,
    CMP_NE  = 3'd1,
    CMP_LT  = 3'd2,
    CMP_LTU = 3'd3,
    CMP_GE  = 3'd4,
    CMP_GEU = 3'd5
} cmp_op_e;

// ALU operations
typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SRA = 3'd7
} alu_op_e;

// Station select on dispatch
typedef enum logic {
    UNIT_CMP = 1'b0,
    UNIT_ALU = 1'b1
} unit_e;

endpackage : tomasulo_pkg

//--- rob_value_file.sv
`timescale 1ns/1ps

module rob_value_file #(
    parameter int ROB_ENTRIES = 16,
    localparam int TAG_W = $clog2(ROB_ENTRIES)
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                seed_we_i,
    input  logic [TAG_W-1:0]    seed_tag_i,
    input  tomasulo_pkg::word_t seed_value_i,
    input  logic                cdb_valid_i,
    input  logic [TAG_W-1:0]    cdb_tag_i,
    input  tomasulo_pkg::word_t cdb_value_i,
    input  logic [TAG_W-1:0]    rd1_tag_i,
    input  logic [TAG_W-1:0]    rd2_tag_i,
    output logic                rd1_ready_o,
    output tomasulo_pkg::word_t rd1_value_o,
    output logic                rd2_ready_o,
    output tomasulo_pkg::word_t rd2_value_o
);
import tomasulo_pkg::*;

word_t                  values [ROB_ENTRIES];
logic [ROB_ENTRIES-1:0] ready;
logic                   cdb_hit1;
logic                   cdb_hit2;

// Ready bits, flush drops every known result
always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        ready <= '0;
    end else if (flush_i) begin
        ready <= '0;
    end else begin
        if (seed_we_i) begin
            ready[seed_tag_i] <= 1'b1;
        end
        if (cdb_valid_i) begin
            ready[cdb_tag_i] <= 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (seed_we_i) begin
        values[seed_tag_i] <= seed_value_i;
    end
    if (cdb_valid_i) begin
        values[cdb_tag_i] <= cdb_value_i;
    end
end

// Dispatch reads see a broadcast in the same cycle
assign cdb_hit1    = cdb_valid_i && (cdb_tag_i == rd1_tag_i);
assign cdb_hit2    = cdb_valid_i && (cdb_tag_i == rd2_tag_i);
assign rd1_ready_o = ready[rd1_tag_i] || cdb_hit1;
assign rd2_ready_o = ready[rd2_tag_i] || cdb_hit2;
assign rd1_value_o = cdb_hit1 ? cdb_value_i : values[rd1_tag_i];
assign rd2_value_o = cdb_hit2 ? cdb_value_i : values[rd2_tag_i];

// A seeded tag is never one still in flight on the CDB
a_seed_cdb_clash: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(seed_we_i && cdb_valid_i && (seed_tag_i == cdb_tag_i)));

endmodule : rob_value_file

//--- cmp_rs.sv
`timescale 1ns/1ps

module cmp_rs #(
    parameter int ROB_ENTRIES = 16,
    parameter int RS_DEPTH    = 4,
    localparam int TAG_W = $clog2(ROB_ENTRIES)
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                load_i,
    input  logic [2:0]          op_i,
    input  logic [TAG_W-1:0]    src1_tag_i,
    input  logic [TAG_W-1:0]    src2_tag_i,
    input  logic [TAG_W-1:0]    dest_tag_i,
    input  logic                src1_ready_i,
    input  tomasulo_pkg::word_t src1_value_i,
    input  logic                src2_ready_i,
    input  tomasulo_pkg::word_t src2_value_i,
    input  logic                cdb_valid_i,
    input  logic [TAG_W-1:0]    cdb_tag_i,
    input  tomasulo_pkg::word_t cdb_value_i,
    input  logic                grant_i,
    output logic                full_o,
    output logic                req_o,
    output logic [TAG_W-1:0]    req_tag_o,
    output tomasulo_pkg::word_t req_value_o
);
import tomasulo_pkg::*;

localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
localparam int CNT_W = $clog2(RS_DEPTH + 1);

// Entry table
logic [RS_DEPTH-1:0] busy;
logic [RS_DEPTH-1:0] busy_nxt;
cmp_op_e             ent_op   [RS_DEPTH];
logic                s1_rdy   [RS_DEPTH];
logic                s2_rdy   [RS_DEPTH];
logic [TAG_W-1:0]    s1_tag   [RS_DEPTH];
logic [TAG_W-1:0]    s2_tag   [RS_DEPTH];
logic [TAG_W-1:0]    ent_dest [RS_DEPTH];
word_t               s1_val   [RS_DEPTH];
word_t               s2_val   [RS_DEPTH];

logic [IDX_W-1:0] free_idx;
logic [IDX_W-1:0] sel_idx;
logic             sel_found;
logic [CNT_W-1:0] busy_cnt;
logic             do_load;
logic             do_issue;
logic             iss_adv;

// Compare stage operands
logic             iss_valid;
cmp_op_e          iss_op;
word_t            iss_a;
word_t            iss_b;
logic [TAG_W-1:0] iss_tag;
logic             cmp_true;

// Lowest free slot and lowest entry with both operands present
always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_found = 1'b0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
        if (!busy[i]) begin
            free_idx = IDX_W'(i);
        end
        if (busy[i] && s1_rdy[i] && s2_rdy[i]) begin
            sel_found = 1'b1;
            sel_idx   = IDX_W'(i);
        end
    end
end

assign do_load  = load_i && !full_o;
assign iss_adv  = iss_valid && (!req_o || grant_i);
assign do_issue = sel_found && (!iss_valid || iss_adv);

always_comb begin
    busy_nxt = busy;
    if (do_issue) begin
        busy_nxt[sel_idx] = 1'b0;
    end
    if (do_load) begin
        busy_nxt[free_idx] = 1'b1;
    end
    busy_cnt = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
        busy_cnt = busy_cnt + CNT_W'(busy_nxt[i]);
    end
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        busy      <= '0;
        full_o    <= 1'b0;
        iss_valid <= 1'b0;
        req_o     <= 1'b0;
    end else if (flush_i) begin
        busy      <= '0;
        full_o    <= 1'b0;
        iss_valid <= 1'b0;
        req_o     <= 1'b0;
    end else begin
        busy   <= busy_nxt;
        full_o <= (busy_cnt == CNT_W'(RS_DEPTH));
        if (do_issue) begin
            iss_valid <= 1'b1;
        end else if (iss_adv) begin
            iss_valid <= 1'b0;
        end
        if (iss_adv) begin
            req_o <= 1'b1;
        end else if (grant_i) begin
            req_o <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    // Wakeup of waiting operands from the CDB
    for (int i = 0; i < RS_DEPTH; i++) begin
        if (cdb_valid_i && busy[i]) begin
            if (!s1_rdy[i] && (s1_tag[i] == cdb_tag_i)) begin
                s1_rdy[i] <= 1'b1;
                s1_val[i] <= cdb_value_i;
            end
            if (!s2_rdy[i] && (s2_tag[i] == cdb_tag_i)) begin
                s2_rdy[i] <= 1'b1;
                s2_val[i] <= cdb_value_i;
            end
        end
    end
    if (do_load) begin
        ent_op[free_idx]   <= cmp_op_e'(op_i);
        s1_rdy[free_idx]   <= src1_ready_i;
        s2_rdy[free_idx]   <= src2_ready_i;
        s1_tag[free_idx]   <= src1_tag_i;
        s2_tag[free_idx]   <= src2_tag_i;
        s1_val[free_idx]   <= src1_value_i;
        s2_val[free_idx]   <= src2_value_i;
        ent_dest[free_idx] <= dest_tag_i;
    end
    if (do_issue) begin
        iss_op  <= ent_op[sel_idx];
        iss_a   <= s1_val[sel_idx];
        iss_b   <= s2_val[sel_idx];
        iss_tag <= ent_dest[sel_idx];
    end
    if (iss_adv) begin
        req_tag_o   <= iss_tag;
        req_value_o <= word_t'(cmp_true);
    end
end

always_comb begin
    case (iss_op)
        CMP_EQ:  cmp_true = (iss_a == iss_b);
        CMP_NE:  cmp_true = (iss_a != iss_b);
        CMP_LT:  cmp_true = ($signed(iss_a) < $signed(iss_b));
        CMP_LTU: cmp_true = (iss_a < iss_b);
        CMP_GE:  cmp_true = ($signed(iss_a) >= $signed(iss_b));
        CMP_GEU: cmp_true = (iss_a >= iss_b);
        default: cmp_true = 1'b0;
    endcase
end

// Dispatcher honours the full flag
a_no_load_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    load_i |-> !full_o);

// A pending result holds until the arbiter takes it
a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
    req_o && !grant_i |=> req_o && $stable(req_tag_o) && $stable(req_value_o));

endmodule : cmp_rs

//--- alu_rs.sv
`timescale 1ns/1ps

module alu_rs #(
    parameter int ROB_ENTRIES = 16,
    parameter int RS_DEPTH    = 4,
    localparam int TAG_W = $clog2(ROB_ENTRIES)
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                load_i,
    input  logic [2:0]          op_i,
    input  logic [TAG_W-1:0]    src1_tag_i,
    input  logic [TAG_W-1:0]    src2_tag_i,
    input  logic [TAG_W-1:0]    dest_tag_i,
    input  logic                src1_ready_i,
    input  tomasulo_pkg::word_t src1_value_i,
    input  logic                src2_ready_i,
    input  tomasulo_pkg::word_t src2_value_i,
    input  logic                cdb_valid_i,
    input  logic [TAG_W-1:0]    cdb_tag_i,
    input  tomasulo_pkg::word_t cdb_value_i,
    input  logic                grant_i,
    output logic                full_o,
    output logic                req_o,
    output logic [TAG_W-1:0]    req_tag_o,
    output tomasulo_pkg::word_t req_value_o
);
import tomasulo_pkg::*;

localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
localparam int CNT_W = $clog2(RS_DEPTH + 1);

logic [RS_DEPTH-1:0] busy;
logic [RS_DEPTH-1:0] busy_nxt;
alu_op_e             ent_op   [RS_DEPTH];
logic                s1_rdy   [RS_DEPTH];
logic                s2_rdy   [RS_DEPTH];
logic [TAG_W-1:0]    s1_tag   [RS_DEPTH];
logic [TAG_W-1:0]    s2_tag   [RS_DEPTH];
logic [TAG_W-1:0]    ent_dest [RS_DEPTH];
word_t               s1_val   [RS_DEPTH];
word_t               s2_val   [RS_DEPTH];

logic [IDX_W-1:0] free_idx;
logic [IDX_W-1:0] sel_idx;
logic             sel_found;
logic [CNT_W-1:0] busy_cnt;
logic             do_load;
logic             do_issue;
logic             iss_adv;

// ALU stage operands
logic             iss_valid;
alu_op_e          iss_op;
word_t            iss_a;
word_t            iss_b;
logic [TAG_W-1:0] iss_tag;
word_t            alu_result;

always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_found = 1'b0;
    // Walk downwards so the lowest index wins
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
        if (!busy[i]) begin
            free_idx = IDX_W'(i);
        end
        if (busy[i] && s1_rdy[i] && s2_rdy[i]) begin
            sel_found = 1'b1;
            sel_idx   = IDX_W'(i);
        end
    end
end

assign do_load  = load_i && !full_o;
assign iss_adv  = iss_valid && (!req_o || grant_i);
assign do_issue = sel_found && (!iss_valid || iss_adv);

// Occupancy after this edge drives the registered full flag
always_comb begin
    busy_nxt = busy;
    if (do_issue) begin
        busy_nxt[sel_idx] = 1'b0;
    end
    if (do_load) begin
        busy_nxt[free_idx] = 1'b1;
    end
    busy_cnt = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
        busy_cnt = busy_cnt + CNT_W'(busy_nxt[i]);
    end
end

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        busy      <= '0;
        full_o    <= 1'b0;
        iss_valid <= 1'b0;
        req_o     <= 1'b0;
    end else if (flush_i) begin
        busy      <= '0;
        full_o    <= 1'b0;
        iss_valid <= 1'b0;
        req_o     <= 1'b0;
    end else begin
        busy   <= busy_nxt;
        full_o <= (busy_cnt == CNT_W'(RS_DEPTH));
        if (do_issue) begin
            iss_valid <= 1'b1;
        end else if (iss_adv) begin
            iss_valid <= 1'b0;
        end
        if (iss_adv) begin
            req_o <= 1'b1;
        end else if (grant_i) begin
            req_o <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
        if (cdb_valid_i && busy[i]) begin
            if (!s1_rdy[i] && (s1_tag[i] == cdb_tag_i)) begin
                s1_rdy[i] <= 1'b1;
                s1_val[i] <= cdb_value_i;
            end
            if (!s2_rdy[i] && (s2_tag[i] == cdb_tag_i)) begin
                s2_rdy[i] <= 1'b1;
                s2_val[i] <= cdb_value_i;
            end
        end
    end
    if (do_load) begin
        ent_op[free_idx]   <= alu_op_e'(op_i);
        s1_rdy[free_idx]   <= src1_ready_i;
        s2_rdy[free_idx]   <= src2_ready_i;
        s1_tag[free_idx]   <= src1_tag_i;
        s2_tag[free_idx]   <= src2_tag_i;
        s1_val[free_idx]   <= src1_value_i;
        s2_val[free_idx]   <= src2_value_i;
        ent_dest[free_idx] <= dest_tag_i;
    end
    if (do_issue) begin
        iss_op  <= ent_op[sel_idx];
        iss_a   <= s1_val[sel_idx];
        iss_b   <= s2_val[sel_idx];
        iss_tag <= ent_dest[sel_idx];
    end
    if (iss_adv) begin
        req_tag_o   <= iss_tag;
        req_value_o <= alu_result;
    end
end

// Shifts take the low 5 bits of the second operand
always_comb begin
    case (iss_op)
        ALU_ADD: alu_result = iss_a + iss_b;
        ALU_SUB: alu_result = iss_a - iss_b;
        ALU_AND: alu_result = iss_a & iss_b;
        ALU_OR:  alu_result = iss_a | iss_b;
        ALU_XOR: alu_result = iss_a ^ iss_b;
        ALU_SLL: alu_result = iss_a << iss_b[4:0];
        ALU_SRL: alu_result = iss_a >> iss_b[4:0];
        ALU_SRA: alu_result = word_t'($signed(iss_a) >>> iss_b[4:0]);
        default: alu_result = '0;
    endcase
end

a_no_load_full: assert property (@(posedge clk) disable iff (!rst_n_i)
    load_i |-> !full_o);

a_req_hold: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
    req_o && !grant_i |=> req_o && $stable(req_tag_o) && $stable(req_value_o));

endmodule : alu_rs

//--- cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int ROB_ENTRIES = 16,
    localparam int TAG_W = $clog2(ROB_ENTRIES)
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                cmp_req_i,
    input  logic [TAG_W-1:0]    cmp_tag_i,
    input  tomasulo_pkg::word_t cmp_value_i,
    input  logic                alu_req_i,
    input  logic [TAG_W-1:0]    alu_tag_i,
    input  tomasulo_pkg::word_t alu_value_i,
    output logic                cmp_grant_o,
    output logic                alu_grant_o,
    output logic                cdb_valid_o,
    output logic [TAG_W-1:0]    cdb_tag_o,
    output tomasulo_pkg::word_t cdb_value_o
);

// High when the ALU station won the last grant
logic last_alu;

// Nothing is broadcast while a flush empties the stations
assign cmp_grant_o = !flush_i && cmp_req_i && (!alu_req_i || last_alu);
assign alu_grant_o = !flush_i && alu_req_i && (!cmp_req_i || !last_alu);

always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
        last_alu <= 1'b0;
    end else if (flush_i) begin
        last_alu <= 1'b0;
    end else if (cmp_grant_o || alu_grant_o) begin
        last_alu <= alu_grant_o;
    end
end

assign cdb_valid_o = cmp_grant_o || alu_grant_o;
assign cdb_tag_o   = alu_grant_o ? alu_tag_i : cmp_tag_i;
assign cdb_value_o = alu_grant_o ? alu_value_i : cmp_value_i;

// At most one owner of the CDB, and only a requester gets it
a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({cmp_grant_o, alu_grant_o})
    && (!cmp_grant_o || cmp_req_i) && (!alu_grant_o || alu_req_i));

endmodule : cdb_arbiter

//--- exec_core.sv
`timescale 1ns/1ps

module exec_core #(
    parameter int ROB_ENTRIES = 16,
    parameter int RS_DEPTH    = 4,
    localparam int TAG_W = $clog2(ROB_ENTRIES)
) (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                disp_valid_i,
    input  tomasulo_pkg::unit_e disp_unit_i,
    input  logic [2:0]          disp_op_i,
    input  logic [TAG_W-1:0]    disp_src1_tag_i,
    input  logic [TAG_W-1:0]    disp_src2_tag_i,
    input  logic [TAG_W-1:0]    disp_dest_tag_i,
    input  logic                seed_we_i,
    input  logic [TAG_W-1:0]    seed_tag_i,
    input  tomasulo_pkg::word_t seed_value_i,
    output logic                cmp_full_o,
    output logic                alu_full_o,
    output logic                cdb_valid_o,
    output logic [TAG_W-1:0]    cdb_tag_o,
    output tomasulo_pkg::word_t cdb_value_o
);
import tomasulo_pkg::*;

logic             cmp_load;
logic             alu_load;
logic             src1_ready;
logic             src2_ready;
word_t            src1_value;
word_t            src2_value;
logic             cmp_req;
logic             alu_req;
logic [TAG_W-1:0] cmp_tag;
logic [TAG_W-1:0] alu_tag;
word_t            cmp_value;
word_t            alu_value;
logic             cmp_grant;
logic             alu_grant;

// Steer the dispatch to one station
assign cmp_load = disp_valid_i && (disp_unit_i == UNIT_CMP);
assign alu_load = disp_valid_i && (disp_unit_i == UNIT_ALU);

rob_value_file #(.ROB_ENTRIES(ROB_ENTRIES)) u_value_file (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .seed_we_i    (seed_we_i),
    .seed_tag_i   (seed_tag_i),
    .seed_value_i (seed_value_i),
    .cdb_valid_i  (cdb_valid_o),
    .cdb_tag_i    (cdb_tag_o),
    .cdb_value_i  (cdb_value_o),
    .rd1_tag_i    (disp_src1_tag_i),
    .rd2_tag_i    (disp_src2_tag_i),
    .rd1_ready_o  (src1_ready),
    .rd1_value_o  (src1_value),
    .rd2_ready_o  (src2_ready),
    .rd2_value_o  (src2_value)
);

cmp_rs #(.ROB_ENTRIES(ROB_ENTRIES), .RS_DEPTH(RS_DEPTH)) u_cmp_rs (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .load_i       (cmp_load),
    .op_i         (disp_op_i),
    .src1_tag_i   (disp_src1_tag_i),
    .src2_tag_i   (disp_src2_tag_i),
    .dest_tag_i   (disp_dest_tag_i),
    .src1_ready_i (src1_ready),
    .src1_value_i (src1_value),
    .src2_ready_i (src2_ready),
    .src2_value_i (src2_value),
    .cdb_valid_i  (cdb_valid_o),
    .cdb_tag_i    (cdb_tag_o),
    .cdb_value_i  (cdb_value_o),
    .grant_i      (cmp_grant),
    .full_o       (cmp_full_o),
    .req_o        (cmp_req),
    .req_tag_o    (cmp_tag),
    .req_value_o  (cmp_value)
);

alu_rs #(.ROB_ENTRIES(ROB_ENTRIES), .RS_DEPTH(RS_DEPTH)) u_alu_rs (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .load_i       (alu_load),
    .op_i         (disp_op_i),
    .src1_tag_i   (disp_src1_tag_i),
    .src2_tag_i   (disp_src2_tag_i),
    .dest_tag_i   (disp_dest_tag_i),
    .src1_ready_i (src1_ready),
    .src1_value_i (src1_value),
    .src2_ready_i (src2_ready),
    .src2_value_i (src2_value),
    .cdb_valid_i  (cdb_valid_o),
    .cdb_tag_i    (cdb_tag_o),
    .cdb_value_i  (cdb_value_o),
    .grant_i      (alu_grant),
    .full_o       (alu_full_o),
    .req_o        (alu_req),
    .req_tag_o    (alu_tag),
    .req_value_o  (alu_value)
);

cdb_arbiter #(.ROB_ENTRIES(ROB_ENTRIES)) u_cdb_arbiter (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .cmp_req_i    (cmp_req),
    .cmp_tag_i    (cmp_tag),
    .cmp_value_i  (cmp_value),
    .alu_req_i    (alu_req),
    .alu_tag_i    (alu_tag),
    .alu_value_i  (alu_value),
    .cmp_grant_o  (cmp_grant),
    .alu_grant_o  (alu_grant),
    .cdb_valid_o  (cdb_valid_o),
    .cdb_tag_o    (cdb_tag_o),
    .cdb_value_o  (cdb_value_o)
);

endmodule : exec_core

//--- tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;
import tomasulo_pkg::*;

localparam int ROB_ENTRIES   = 16;
localparam int RS_DEPTH      = 4;
localparam int TAG_W         = $clog2(ROB_ENTRIES);
localparam int NUM_ROUNDS    = 60;
localparam int ROOM_TIMEOUT  = 100;
localparam int DRAIN_TIMEOUT = 200;
localparam int QUIET_CYCLES  = 16;
localparam int WATCHDOG_NS   = 2000000;
localparam logic [31:0] SEED = 32'hfe92_57c6;

// Model view of one result slot
typedef enum int {
    TAG_FREE,
    TAG_KNOWN,
    TAG_PENDING,
    TAG_RESERVED
} tag_state_e;

logic             clk;
logic             rst_n_i;
logic             flush_i;
logic             disp_valid_i;
unit_e            disp_unit_i;
logic [2:0]       disp_op_i;
logic [TAG_W-1:0] disp_src1_tag_i;
logic [TAG_W-1:0] disp_src2_tag_i;
logic [TAG_W-1:0] disp_dest_tag_i;
logic             seed_we_i;
logic [TAG_W-1:0] seed_tag_i;
word_t            seed_value_i;
logic             cmp_full_o;
logic             alu_full_o;
logic             cdb_valid_o;
logic [TAG_W-1:0] cdb_tag_o;
word_t            cdb_value_o;

// Reference model state
tag_state_e  tag_state [ROB_ENTRIES];
word_t       model_val [ROB_ENTRIES];
int          pending_count;
int          dispatched_count;
int          broadcast_count;
int          checks;
int          errors;
bit          timed_out;
logic [31:0] seed_dummy;

exec_core #(.ROB_ENTRIES(ROB_ENTRIES), .RS_DEPTH(RS_DEPTH)) UUT (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush_i),
    .disp_valid_i    (disp_valid_i),
    .disp_unit_i     (disp_unit_i),
    .disp_op_i       (disp_op_i),
    .disp_src1_tag_i (disp_src1_tag_i),
    .disp_src2_tag_i (disp_src2_tag_i),
    .disp_dest_tag_i (disp_dest_tag_i),
    .seed_we_i       (seed_we_i),
    .seed_tag_i      (seed_tag_i),
    .seed_value_i    (seed_value_i),
    .cmp_full_o      (cmp_full_o),
    .alu_full_o      (alu_full_o),
    .cdb_valid_o     (cdb_valid_o),
    .cdb_tag_o       (cdb_tag_o),
    .cdb_value_o     (cdb_value_o)
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

// RV32I compare semantics, signed order taken by flipping the sign bits
function automatic word_t cmp_model(input cmp_op_e op, input word_t a, input word_t b);
    logic lt_s;
    logic lt_u;
    logic res;
    lt_u = (a < b);
    lt_s = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
    case (op)
        CMP_EQ:  res = (a == b);
        CMP_NE:  res = (a != b);
        CMP_LT:  res = lt_s;
        CMP_LTU: res = lt_u;
        CMP_GE:  res = !lt_s;
        CMP_GEU: res = !lt_u;
        default: res = 1'b0;
    endcase
    return {31'b0, res};
endfunction

function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    logic [4:0] sh;
    word_t      r;
    sh = b[4:0];
    case (op)
        ALU_ADD: r = a + b;
        ALU_SUB: r = a + ~b + 32'd1;
        ALU_AND: r = a & b;
        ALU_OR:  r = a | b;
        ALU_XOR: r = a ^ b;
        ALU_SLL: r = a << sh;
        ALU_SRL: r = a >> sh;
        // Fill the vacated upper bits with the sign
        ALU_SRA: r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
        default: r = '0;
    endcase
    return r;
endfunction

function automatic word_t model_result(input unit_e unit, input logic [2:0] op,
                                       input word_t a, input word_t b);
    if (unit == UNIT_CMP) begin
        return cmp_model(cmp_op_e'(op), a, b);
    end
    return alu_model(alu_op_e'(op), a, b);
endfunction

function automatic int count_state(input tag_state_e st);
    int n;
    n = 0;
    for (int t = 0; t < ROB_ENTRIES; t++) begin
        if (tag_state[t] == st) begin
            n++;
        end
    end
    return n;
endfunction

// Random slot in the given state, -1 if there is none
function automatic int pick_tag(input tag_state_e st);
    int cands[$];
    for (int t = 0; t < ROB_ENTRIES; t++) begin
        if (tag_state[t] == st) begin
            cands.push_back(t);
        end
    end
    if (cands.size() == 0) begin
        return -1;
    end
    return cands[$urandom % cands.size()];
endfunction

// Outstanding results are preferred so that chains form
function automatic int pick_source();
    if (count_state(TAG_PENDING) != 0 && $urandom % 2 == 0) begin
        return pick_tag(TAG_PENDING);
    end
    return pick_tag(TAG_KNOWN);
endfunction

function automatic unit_e random_unit();
    return ($urandom % 2 == 0) ? UNIT_CMP : UNIT_ALU;
endfunction

function automatic logic [2:0] random_op(input unit_e unit);
    return (unit == UNIT_CMP) ? 3'($urandom % 6) : 3'($urandom % 8);
endfunction

// Small values now and then so that equal operands show up
function automatic word_t random_word();
    if ($urandom % 4 == 0) begin
        return word_t'($urandom % 8);
    end
    return $urandom;
endfunction

function automatic logic station_full(input unit_e unit);
    return (unit == UNIT_CMP) ? cmp_full_o : alu_full_o;
endfunction

function automatic string full_name(input unit_e unit);
    return (unit == UNIT_CMP) ? "cmp_full_o" : "alu_full_o";
endfunction

task automatic reset_model();
    for (int t = 0; t < ROB_ENTRIES; t++) begin
        tag_state[t] = TAG_FREE;
        model_val[t] = '0;
    end
    pending_count = 0;
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
        errors++;
        $display("** Error at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
    end
endtask

// CDB is sampled mid-cycle, once every cycle
task automatic sample_cdb();
    int tag;
    if (cdb_valid_o === 1'b1) begin
        tag = int'(cdb_tag_o);
        broadcast_count++;
        checks++;
        if (tag_state[tag] != TAG_PENDING) begin
            errors++;
            $display("Unexpected CDB broadcast of tag %0d at %0t, no such operation in flight",
                     tag, $time);
        end else begin
            if (cdb_value_o !== model_val[tag]) begin
                errors++;
                $display("** Error at %0t: cdb_value_o (tag %0d) expected %h, got %h",
                         $time, tag, model_val[tag], cdb_value_o);
            end
            tag_state[tag] = TAG_KNOWN;
            pending_count--;
        end
    end
endtask

task automatic next_cycle();
    @(negedge clk);
    sample_cdb();
    @(posedge clk);
    #1;
endtask

task automatic wait_room(input unit_e unit);
    int waited;
    waited = 0;
    while (station_full(unit) && waited < ROOM_TIMEOUT) begin
        next_cycle();
        waited++;
    end
    if (station_full(unit)) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %s stayed high, no room for a dispatch", full_name(unit));
    end
endtask

task automatic dispatch_op(input unit_e unit, input logic [2:0] op,
                           input int src1, input int src2, input int dest);
    wait_room(unit);
    if (!timed_out) begin
        model_val[dest] = model_result(unit, op, model_val[src1], model_val[src2]);
        tag_state[dest] = TAG_PENDING;
        pending_count++;
        dispatched_count++;
        disp_valid_i    = 1'b1;
        disp_unit_i     = unit;
        disp_op_i       = op;
        disp_src1_tag_i = TAG_W'(src1);
        disp_src2_tag_i = TAG_W'(src2);
        disp_dest_tag_i = TAG_W'(dest);
        next_cycle();
        disp_valid_i = 1'b0;
    end
endtask

task automatic drain();
    int waited;
    waited = 0;
    while (pending_count != 0 && waited < DRAIN_TIMEOUT) begin
        next_cycle();
        waited++;
    end
    checks++;
    if (pending_count != 0) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: %0d operations never appeared on the CDB", pending_count);
    end
endtask

task automatic seed_tags(input int n);
    int tag;
    for (int i = 0; i < n; i++) begin
        tag = pick_tag(TAG_FREE);
        model_val[tag] = random_word();
        seed_we_i    = 1'b1;
        seed_tag_i   = TAG_W'(tag);
        seed_value_i = model_val[tag];
        next_cycle();
        tag_state[tag] = TAG_KNOWN;
    end
    seed_we_i = 1'b0;
endtask

task automatic flush_core();
    flush_i = 1'b1;
    reset_model();
    next_cycle();
    flush_i = 1'b0;
    check_bit("cmp_full_o", 1'b0, cmp_full_o);
    check_bit("alu_full_o", 1'b0, alu_full_o);
endtask

task automatic random_ops(input int max_ops);
    unit_e      unit;
    logic [2:0] op;
    int         src1;
    int         src2;
    int         n;
    n = 0;
    while (n < max_ops && count_state(TAG_FREE) > 2 && !timed_out) begin
        unit = random_unit();
        wait_room(unit);
        src1 = pick_source();
        src2 = pick_source();
        // Take a tag that is on the CDB right now to hit the wakeup bypass
        if (cdb_valid_o === 1'b1 && tag_state[cdb_tag_o] == TAG_PENDING
            && $urandom % 2 == 0) begin
            src1 = int'(cdb_tag_o);
        end
        op = random_op(unit);
        dispatch_op(unit, op, src1, src2, pick_tag(TAG_FREE));
        repeat ($urandom % 3) begin
            next_cycle();
        end
        n++;
    end
endtask

// Consumers wait on a slot whose producer is sent only after the station is full
task automatic fill_station(input unit_e unit);
    unit_e      other;
    logic [2:0] op;
    int         x;
    int         src_a;
    int         src_b;
    other = (unit == UNIT_CMP) ? UNIT_ALU : UNIT_CMP;
    src_a = pick_tag(TAG_KNOWN);
    src_b = pick_tag(TAG_KNOWN);
    op    = random_op(other);
    x     = pick_tag(TAG_FREE);
    model_val[x] = model_result(other, op, model_val[src_a], model_val[src_b]);
    tag_state[x] = TAG_RESERVED;
    for (int i = 0; i < RS_DEPTH; i++) begin
        dispatch_op(unit, random_op(unit), x, pick_tag(TAG_KNOWN), pick_tag(TAG_FREE));
    end
    check_bit(full_name(unit), 1'b1, station_full(unit));
    dispatch_op(other, op, src_a, src_b, x);
    drain();
    check_bit(full_name(unit), 1'b0, station_full(unit));
endtask

task automatic flush_pending();
    unit_e unit;
    unit_e other;
    int    x;
    x = pick_tag(TAG_FREE);
    tag_state[x] = TAG_RESERVED;
    model_val[x] = '0;
    unit  = random_unit();
    other = (unit == UNIT_CMP) ? UNIT_ALU : UNIT_CMP;
    // None of these can issue, so the station is still full at the flush
    for (int i = 0; i < RS_DEPTH; i++) begin
        dispatch_op(unit, random_op(unit), x, pick_tag(TAG_KNOWN), pick_tag(TAG_FREE));
    end
    check_bit(full_name(unit), 1'b1, station_full(unit));
    // Still waiting in the other station when the flush arrives
    dispatch_op(other, random_op(other), pick_source(), pick_source(), pick_tag(TAG_FREE));
    flush_core();
    for (int n = 0; n < QUIET_CYCLES; n++) begin
        next_cycle();
    end
endtask

initial begin
    int round;
    seed_dummy       = $urandom(SEED);
    rst_n_i          = 1'b0;
    flush_i          = 1'b0;
    disp_valid_i     = 1'b0;
    disp_unit_i      = UNIT_CMP;
    disp_op_i        = '0;
    disp_src1_tag_i  = '0;
    disp_src2_tag_i  = '0;
    disp_dest_tag_i  = '0;
    seed_we_i        = 1'b0;
    seed_tag_i       = '0;
    seed_value_i     = '0;
    dispatched_count = 0;
    broadcast_count  = 0;
    checks           = 0;
    errors           = 0;
    timed_out        = 1'b0;
    reset_model();

    repeat (8) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    next_cycle();
    check_bit("cdb_valid_o", 1'b0, cdb_valid_o);
    check_bit("cmp_full_o", 1'b0, cmp_full_o);
    check_bit("alu_full_o", 1'b0, alu_full_o);

    for (round = 0; round < NUM_ROUNDS && !timed_out; round++) begin
        flush_core();
        seed_tags(3 + int'($urandom % 3));
        if (round % 5 == 2) begin
            fill_station((round % 2 == 0) ? UNIT_CMP : UNIT_ALU);
        end
        if (round % 4 == 3) begin
            flush_pending();
        end else begin
            random_ops(12);
            drain();
        end
    end

    $display("Summary: %0d operations, %0d broadcasts, %0d checks, %0d errors",
             dispatched_count, broadcast_count, checks, errors);
    if (errors == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

// Hard limit on simulated time
initial begin
    #(WATCHDOG_NS);
    $display("Simulation did not finish within %0d ns", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
end

endmodule : tb_exec_core

//--- src.f
tomasulo_pkg.sv
rob_value_file.sv
cmp_rs.sv
alu_rs.sv
cdb_arbiter.sv
exec_core.sv
tb_exec_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the exec_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_exec_core -f src.f -o tb_exec_core

out=$(./obj_dir/tb_exec_core) || true
echo "$out"

# The run passes only if the testbench printed its pass line
echo "$out" | grep -q "TESTBENCH PASSED"
